// ==== tb.f ====
rtl/hazard_pkg.sv
rtl/inst_decoder.sv
rtl/stage_reg.sv
rtl/hazard_unit.sv
rtl/retire_tracker.sv
rtl/pipe_ctrl_top.sv
tb/tb_pipe_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and decide on the log contents
rm -rf obj_dir sim.log

verilator --binary --assert --timing -f tb.f --top-module tb_pipe_ctrl -o tb_pipe_ctrl \
  && ./obj_dir/tb_pipe_ctrl > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/tb_pipe_ctrl.sv ====
module tb_pipe_ctrl;

  localparam int reset_cycles = 8;
  localparam int phase_cycles = 480;
  localparam int num_phases   = 4;
  localparam int drain_cycles = 32;
  // reset, the four stimulus phases and the drain, plus a small margin
  localparam int cycle_limit  = reset_cycles + num_phases * phase_cycles + drain_cycles + 40;

  logic                                    clk;
  logic                                    rst_n;
  hazard_pkg::inst_word_u                  inst;
  logic                                    inst_valid;
  logic                                    pc_src;
  logic                                    axil_en;
  logic                                    axil_done_read;
  logic                                    axil_done_write;
  logic                                    fetch_stall;
  logic [hazard_pkg::num_stages-1:0]       stall;
  logic [hazard_pkg::num_stages-1:0]       flush;
  hazard_pkg::fwd_sel_t                    fwd;
  logic                                    retire_valid;
  logic [4:0]                              retire_rd;
  logic                                    retire_trap;
  logic [31:0]                             retire_count;

  // shadow pipeline and the values it predicts for the DUT ports
  hazard_pkg::stage_meta_t                 mst [hazard_pkg::num_stages];
  hazard_pkg::stage_meta_t                 exp_dec;
  hazard_pkg::fwd_sel_t                    exp_fwd;
  logic [hazard_pkg::num_stages-1:0]       exp_stall;
  logic [hazard_pkg::num_stages-1:0]       exp_flush;
  logic                                    exp_bus_stall;
  logic                                    exp_load_use;
  logic                                    exp_retire_valid;
  logic [4:0]                              exp_retire_rd;
  logic                                    exp_retire_trap;
  logic [31:0]                             exp_count;

  logic [31:0] rng_state = 32'hd6f3_2730;
  logic        fetch_held;
  int          cycle_count = 0;
  int          mismatch_count = 0;
  int          unreached_count = 0;
  int          seen_load_use = 0;
  int          seen_mem2_rdata = 0;
  int          seen_id_fwd = 0;
  int          seen_branch_flush = 0;
  int          seen_bus_hold = 0;
  int          seen_trap = 0;

  pipe_ctrl_top uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .inst            (inst),
    .inst_valid      (inst_valid),
    .pc_src          (pc_src),
    .axil_en         (axil_en),
    .axil_done_read  (axil_done_read),
    .axil_done_write (axil_done_write),
    .fetch_stall     (fetch_stall),
    .stall           (stall),
    .flush           (flush),
    .fwd             (fwd),
    .retire_valid    (retire_valid),
    .retire_rd       (retire_rd),
    .retire_trap     (retire_trap),
    .retire_count    (retire_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // what ID should hold for a word under the decode rules
  function automatic hazard_pkg::stage_meta_t decode_word(input logic [31:0] w, input logic v);
    hazard_pkg::stage_meta_t m;
    m = '0;
    if (v) begin
      m.valid = 1'b1;
      m.rs1   = w[19:15];
      m.rs2   = w[24:20];
      m.rd    = w[11:7];
      case (w[6:0])
        hazard_pkg::opcode_load: begin
          m.rs2        = 5'd0;
          m.result_src = hazard_pkg::result_src_dmem_rd_data;
        end
        hazard_pkg::opcode_store, hazard_pkg::opcode_branch: begin
          m.rd = 5'd0;
        end
        hazard_pkg::opcode_op: begin
          m.result_src = hazard_pkg::result_src_alu;
        end
        hazard_pkg::opcode_op_imm: begin
          m.rs2 = 5'd0;
        end
        hazard_pkg::opcode_jal, hazard_pkg::opcode_jalr: begin
          // jal has no rs1 either
          // both link through pc plus four
          if (w[6:0] == hazard_pkg::opcode_jal) begin
            m.rs1 = 5'd0;
          end
          m.rs2        = 5'd0;
          m.result_src = hazard_pkg::result_src_pc_plus4;
        end
        hazard_pkg::opcode_lui, hazard_pkg::opcode_auipc: begin
          m.rs1 = 5'd0;
          m.rs2 = 5'd0;
        end
        hazard_pkg::opcode_system: begin
          m.trap = 1'b1;
          m.rs2  = 5'd0;
          // ecall and ebreak name no register at all
          if ((w[14:12] == 3'd0) && (w[31:21] == 11'd0)) begin
            m.rs1 = 5'd0;
            m.rd  = 5'd0;
          end
        end
        default: begin
          m     = '0;
          m.valid = 1'b1;
          m.trap  = 1'b1;
        end
      endcase
    end
    return m;
  endfunction

  // EX operand select that prefers the nearest producer
  function automatic logic [2:0] ex_forward_pick(
    input logic [4:0]              src,
    input hazard_pkg::stage_meta_t mem1,
    input hazard_pkg::stage_meta_t mem2,
    input hazard_pkg::stage_meta_t wb
  );
    logic [2:0] sel;
    sel = hazard_pkg::fwd_no_forward;
    if (src != 5'd0) begin
      if (src == mem1.rd) begin
        sel = hazard_pkg::fwd_mem1_alu_result;
      end else if (src == mem2.rd) begin
        if (mem2.result_src == hazard_pkg::result_src_dmem_rd_data) begin
          sel = hazard_pkg::fwd_mem2_mem_rdata;
        end else begin
          sel = hazard_pkg::fwd_mem2_alu_result;
        end
      end else if (src == wb.rd) begin
        sel = hazard_pkg::fwd_wb_result;
      end
    end
    return sel;
  endfunction

  // random word from loads, ALU ops, branches and a rare ecall on x0 to x3
  function automatic logic [31:0] random_inst(input int phase);
    logic [31:0] r;
    logic [31:0] w;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r    = lcg_next();
    kind = r[31:28];
    rd   = {3'd0, r[9:8]};
    rs1  = {3'd0, r[11:10]};
    rs2  = {3'd0, r[13:12]};
    // the first phase only issues ALU ops, so no stall can happen
    if (phase == 0) begin
      kind = {1'b1, kind[2:0]};
    end
    if (kind < 4'd5) begin
      w = {12'h004, rs1, 3'b010, rd, hazard_pkg::opcode_load};
    end else if (kind < 4'd7) begin
      w = {7'd0, rs2, rs1, 3'b001, r[4:0], hazard_pkg::opcode_branch};
    end else if (kind[0]) begin
      w = {7'd0, rs2, rs1, 3'b000, rd, hazard_pkg::opcode_op};
    end else begin
      w = {r[27:16], rs1, 3'b000, rd, hazard_pkg::opcode_op_imm};
    end
    if ((phase == 3) && (kind == 4'd15) && r[0]) begin
      w = 32'h0000_0073;
    end
    return w;
  endfunction

  assign exp_dec = decode_word(inst.raw, inst_valid);

  always_comb begin
    exp_bus_stall = axil_en & ~(axil_done_read | axil_done_write);
    exp_load_use  = (mst[1].result_src == hazard_pkg::result_src_dmem_rd_data) &&
                    (((mst[0].rs1 != 5'd0) && (mst[0].rs1 == mst[1].rd)) ||
                     ((mst[0].rs2 != 5'd0) && (mst[0].rs2 == mst[1].rd)));
    exp_fwd.ex_a  = ex_forward_pick(mst[1].rs1, mst[2], mst[3], mst[4]);
    exp_fwd.ex_b  = ex_forward_pick(mst[1].rs2, mst[2], mst[3], mst[4]);
    // the ID bypass only fires between two live records
    exp_fwd.id_a  = mst[0].valid && mst[4].valid && (mst[0].rs1 == mst[4].rd);
    exp_fwd.id_b  = mst[0].valid && mst[4].valid && (mst[0].rs2 == mst[4].rd);
    exp_flush[0]  = (pc_src & ~exp_bus_stall) | mst[1].trap | mst[2].trap |
                    mst[3].trap | mst[4].trap;
    exp_flush[1]  = ((pc_src | exp_load_use) & ~exp_bus_stall) | mst[2].trap |
                    mst[3].trap | mst[4].trap;
    exp_flush[2]  = mst[3].trap | mst[4].trap;
    exp_flush[3]  = mst[4].trap;
    exp_flush[4]  = mst[4].trap;
    exp_stall     = {hazard_pkg::num_stages{exp_bus_stall}};
    exp_stall[0]  = exp_load_use | exp_bus_stall;
    // a record frozen in WB by the bus retires only once as it leaves
    exp_retire_valid = mst[4].valid & (~exp_stall[4] | exp_flush[4]);
    exp_retire_rd    = exp_retire_valid ? mst[4].rd : 5'd0;
    exp_retire_trap  = exp_retire_valid & mst[4].trap;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < hazard_pkg::num_stages; i++) begin
        mst[i] <= '0;
      end
      exp_count <= 32'd0;
    end else begin
      if (exp_flush[0]) begin
        mst[0] <= '0;
      end else if (!exp_stall[0]) begin
        mst[0] <= exp_dec;
      end
      for (int i = 1; i < hazard_pkg::num_stages; i++) begin
        if (exp_flush[i]) begin
          mst[i] <= '0;
        end else if (!exp_stall[i]) begin
          mst[i] <= mst[i-1];
        end
      end
      if (exp_retire_valid && !mst[4].trap) begin
        exp_count <= exp_count + 32'd1;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Error %s expected %h actual %h", name, exp_val, act_val);
    mismatch_count = mismatch_count + 1;
  endtask

  task automatic require_seen(input string what, input int count);
    if (count == 0) begin
      $display("stimulus never produced %s", what);
      unreached_count = unreached_count + 1;
    end
  endtask

  // inputs change one unit after the rising edge and all has settled by the falling edge
  stall_levels: assert property (@(negedge clk) disable iff (!rst_n) stall == exp_stall)
    else report_mismatch("stall_levels", {27'd0, exp_stall}, {27'd0, stall});
  flush_levels: assert property (@(negedge clk) disable iff (!rst_n) flush == exp_flush)
    else report_mismatch("flush_levels", {27'd0, exp_flush}, {27'd0, flush});
  fetch_hold: assert property (@(negedge clk) disable iff (!rst_n) fetch_stall == exp_stall[0])
    else report_mismatch("fetch_hold", {31'd0, exp_stall[0]}, {31'd0, fetch_stall});
  forward_selects: assert property (@(negedge clk) disable iff (!rst_n) fwd == exp_fwd)
    else report_mismatch("forward_selects", {24'd0, exp_fwd}, {24'd0, fwd});
  retire_strobe: assert property (@(negedge clk) disable iff (!rst_n)
                                  retire_valid == exp_retire_valid)
    else report_mismatch("retire_strobe", {31'd0, exp_retire_valid}, {31'd0, retire_valid});
  retire_dest: assert property (@(negedge clk) disable iff (!rst_n) retire_rd == exp_retire_rd)
    else report_mismatch("retire_dest", {27'd0, exp_retire_rd}, {27'd0, retire_rd});
  retire_trap_strobe: assert property (@(negedge clk) disable iff (!rst_n)
                                       retire_trap == exp_retire_trap)
    else report_mismatch("retire_trap_strobe", {31'd0, exp_retire_trap}, {31'd0, retire_trap});
  retired_total: assert property (@(negedge clk) disable iff (!rst_n) retire_count == exp_count)
    else report_mismatch("retired_total", exp_count, retire_count);

  // fetch keeps its word for the next cycle whenever the last one ended stalled
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_held <= 1'b0;
    end else begin
      fetch_held <= fetch_stall;
    end
  end

  // tally which hazard situations the random stream actually reached
  always @(negedge clk) begin
    if (rst_n) begin
      if (exp_load_use && !exp_bus_stall) begin
        seen_load_use = seen_load_use + 1;
      end
      if ((exp_fwd.ex_a == hazard_pkg::fwd_mem2_mem_rdata) ||
          (exp_fwd.ex_b == hazard_pkg::fwd_mem2_mem_rdata)) begin
        seen_mem2_rdata = seen_mem2_rdata + 1;
      end
      if (exp_fwd.id_a || exp_fwd.id_b) begin
        seen_id_fwd = seen_id_fwd + 1;
      end
      if (pc_src && !exp_bus_stall) begin
        seen_branch_flush = seen_branch_flush + 1;
      end
      if (exp_bus_stall && mst[4].valid) begin
        seen_bus_hold = seen_bus_hold + 1;
      end
      if (exp_retire_trap) begin
        seen_trap = seen_trap + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic drive_cycle(input int phase);
    logic [31:0] r;
    r = lcg_next();
    if (!fetch_held) begin
      inst       = random_inst(phase);
      inst_valid = (r[27:24] != 4'd0);
    end
    pc_src          = (phase >= 2) && (r[23:21] == 3'd0);
    axil_en         = (phase == 3) && (r[20:19] == 2'd0);
    axil_done_read  = r[18] & r[17];
    axil_done_write = r[16] & r[15] & ~r[18];
  endtask

  initial begin
    rst_n           = 1'b0;
    inst            = '0;
    inst_valid      = 1'b0;
    pc_src          = 1'b0;
    axil_en         = 1'b0;
    axil_done_read  = 1'b0;
    axil_done_write = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int phase = 0; phase < num_phases; phase++) begin
      for (int n = 0; n < phase_cycles; n++) begin
        @(posedge clk);
        #1 drive_cycle(phase);
      end
    end
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
    pc_src     = 1'b0;
    axil_en    = 1'b0;
    repeat (drain_cycles) @(posedge clk);
    @(negedge clk);
    require_seen("a load-use stall", seen_load_use);
    require_seen("a load forwarded from MEM2", seen_mem2_rdata);
    require_seen("an ID bypass", seen_id_fwd);
    require_seen("a branch flush", seen_branch_flush);
    require_seen("a bus stall holding WB", seen_bus_hold);
    require_seen("a retired trap", seen_trap);
    $display("errors: %0d value mismatches, %0d unreached checks",
             mismatch_count, unreached_count);
    if ((mismatch_count == 0) && (unreached_count == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== rtl/pipe_ctrl_top.sv ====
module pipe_ctrl_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  hazard_pkg::inst_word_u            inst,
  input  logic                              inst_valid,
  input  logic                              pc_src,
  input  logic                              axil_en,
  input  logic                              axil_done_read,
  input  logic                              axil_done_write,
  output logic                              fetch_stall,
  output logic [hazard_pkg::num_stages-1:0] stall,
  output logic [hazard_pkg::num_stages-1:0] flush,
  output hazard_pkg::fwd_sel_t              fwd,
  output logic                              retire_valid,
  output logic [4:0]                        retire_rd,
  output logic                              retire_trap,
  output logic [31:0]                       retire_count
);

  // decoded record of the word that fetch presents this cycle
  hazard_pkg::stage_meta_t dec_meta;

  // input and output of every stage register, index 0 is IF/ID
  hazard_pkg::stage_meta_t stage_d [hazard_pkg::num_stages];
  hazard_pkg::stage_meta_t stages  [hazard_pkg::num_stages];

  // the WB record as seen by the tracker
  hazard_pkg::stage_meta_t wb_leave;

  inst_decoder u_decoder (
    .inst       (inst),
    .inst_valid (inst_valid),
    .meta       (dec_meta)
  );

  // IF/ID loads from the decoder and every later slot from the one before it
  for (genvar i = 0; i < hazard_pkg::num_stages; i++) begin : g_stage
    if (i == 0) begin : g_first
      assign stage_d[i] = dec_meta;
    end else begin : g_next
      assign stage_d[i] = stages[i-1];
    end

    stage_reg u_stage_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .stall (stall[i]),
      .flush (flush[i]),
      .d     (stage_d[i]),
      .q     (stages[i])
    );
  end

  hazard_unit u_hazard (
    .stages          (stages),
    .pc_src          (pc_src),
    .axil_en         (axil_en),
    .axil_done_read  (axil_done_read),
    .axil_done_write (axil_done_write),
    .stall           (stall),
    .flush           (flush),
    .fwd             (fwd),
    .fetch_stall     (fetch_stall)
  );

  // WB only retires on the cycle its record actually leaves the stage
  // a held record under bus stall would otherwise be reported every cycle
  always_comb begin
    wb_leave       = stages[hazard_pkg::num_stages-1];
    wb_leave.valid = stages[hazard_pkg::num_stages-1].valid &
                     (~stall[hazard_pkg::num_stages-1] | flush[hazard_pkg::num_stages-1]);
  end

  retire_tracker u_retire (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb           (wb_leave),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_trap  (retire_trap),
    .retire_count (retire_count)
  );

endmodule

// ==== rtl/retire_tracker.sv ====
module retire_tracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  hazard_pkg::stage_meta_t wb,
  output logic                    retire_valid,
  output logic [4:0]              retire_rd,
  output logic                    retire_trap,
  output logic [31:0]             retire_count
);

  logic count_en;

  // the record is only live in the cycle it leaves WB
  assign retire_valid = wb.valid;

  // bubbles report x0 so a stray rd never shows up on the port
  assign retire_rd = wb.valid ? wb.rd : 5'd0;

  // a trapping instruction retires as a trap strobe and does not count
  assign retire_trap = wb.valid & wb.trap;

  assign count_en = wb.valid & ~wb.trap;

  // number of instructions that completed without a trap since reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_count <= 32'd0;
    end else if (count_en) begin
      retire_count <= retire_count + 32'd1;
    end
  end

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit (
  input  hazard_pkg::stage_meta_t                 stages [hazard_pkg::num_stages],
  input  logic                                    pc_src,
  input  logic                                    axil_en,
  input  logic                                    axil_done_read,
  input  logic                                    axil_done_write,
  output logic [hazard_pkg::num_stages-1:0]       stall,
  output logic [hazard_pkg::num_stages-1:0]       flush,
  output hazard_pkg::fwd_sel_t                    fwd,
  output logic                                    fetch_stall
);

  // names for the stage records, index 0 is ID and index 4 is WB
  hazard_pkg::stage_meta_t id_st;
  hazard_pkg::stage_meta_t ex_st;
  hazard_pkg::stage_meta_t mem1_st;
  hazard_pkg::stage_meta_t mem2_st;
  hazard_pkg::stage_meta_t wb_st;

  logic bus_stall;
  logic load_use;
  logic id_rs1_hit_ex;
  logic id_rs2_hit_ex;
  logic trap_mem1_up;
  logic trap_mem2_up;

  assign id_st   = stages[0];
  assign ex_st   = stages[1];
  assign mem1_st = stages[2];
  assign mem2_st = stages[3];
  assign wb_st   = stages[4];

  // picks the youngest producer of src that is older than EX
  // x0 is never forwarded because its value is a constant zero
  function automatic logic [2:0] ex_fwd_sel(
    input logic [4:0]              src,
    input hazard_pkg::stage_meta_t mem1,
    input hazard_pkg::stage_meta_t mem2,
    input hazard_pkg::stage_meta_t wb
  );
    logic [2:0] sel;
    if (src == 5'd0) begin
      sel = hazard_pkg::fwd_no_forward;
    end else if (src == mem1.rd) begin
      sel = hazard_pkg::fwd_mem1_alu_result;
    end else if ((src == mem2.rd) &&
                 (mem2.result_src == hazard_pkg::result_src_dmem_rd_data)) begin
      // load data only exists once the access has come back in MEM2
      sel = hazard_pkg::fwd_mem2_mem_rdata;
    end else if (src == mem2.rd) begin
      sel = hazard_pkg::fwd_mem2_alu_result;
    end else if (src == wb.rd) begin
      sel = hazard_pkg::fwd_wb_result;
    end else begin
      sel = hazard_pkg::fwd_no_forward;
    end
    return sel;
  endfunction

  // a peripheral access in MEM1 is still waiting for its done strobe
  assign bus_stall = axil_en & ~(axil_done_read | axil_done_write);

  // the instruction in ID needs a value that the load in EX has not read yet
  assign id_rs1_hit_ex = (id_st.rs1 != 5'd0) && (id_st.rs1 == ex_st.rd);
  assign id_rs2_hit_ex = (id_st.rs2 != 5'd0) && (id_st.rs2 == ex_st.rd);
  assign load_use = (ex_st.result_src == hazard_pkg::result_src_dmem_rd_data) &&
                    (id_rs1_hit_ex || id_rs2_hit_ex);

  always_comb begin
    fwd.ex_a = ex_fwd_sel(ex_st.rs1, mem1_st, mem2_st, wb_st);
    fwd.ex_b = ex_fwd_sel(ex_st.rs2, mem1_st, mem2_st, wb_st);
  end

  // ID reads the register file while WB writes it, so a match bypasses the write
  // both records must hold a live instruction, which keeps bubbles from matching
  assign fwd.id_a = id_st.valid && wb_st.valid && (id_st.rs1 == wb_st.rd);
  assign fwd.id_b = id_st.valid && wb_st.valid && (id_st.rs2 == wb_st.rd);

  // a trap anywhere from this stage down to WB
  assign trap_mem2_up = mem2_st.trap | wb_st.trap;
  assign trap_mem1_up = mem1_st.trap | trap_mem2_up;

  // a trap only clears stages younger than itself, so it still reaches WB
  // the branch and load-use flushes wait out a bus stall, otherwise the
  // instruction that caused them would be wiped while it is frozen in place
  assign flush[0] = (pc_src & ~bus_stall) | ex_st.trap | trap_mem1_up;
  assign flush[1] = ((pc_src | load_use) & ~bus_stall) | trap_mem1_up;
  assign flush[2] = trap_mem2_up;
  assign flush[3] = wb_st.trap;
  assign flush[4] = wb_st.trap;

  // load-use holds fetch and ID for one cycle while a bubble goes into EX
  assign stall[0] = load_use | bus_stall;
  assign stall[1] = bus_stall;
  assign stall[2] = bus_stall;
  assign stall[3] = bus_stall;
  assign stall[4] = bus_stall;

  // fetch presents the same word again whenever ID cannot take it
  assign fetch_stall = load_use | bus_stall;

endmodule

// ==== rtl/stage_reg.sv ====
module stage_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall,
  input  logic                    flush,
  input  hazard_pkg::stage_meta_t d,
  output hazard_pkg::stage_meta_t q
);

  // one slot of the pipe
  // a flush writes a bubble even while the slot is stalled, so a stage
  // that is being cleared never keeps a stale instruction around
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== rtl/inst_decoder.sv ====
module inst_decoder (
  input  hazard_pkg::inst_word_u  inst,
  input  logic                    inst_valid,
  output hazard_pkg::stage_meta_t meta
);

  // ecall and ebreak share funct3 zero and differ only in imm12
  logic is_env_call;

  assign is_env_call = (inst.i.funct3 == 3'd0) &&
                       ((inst.i.imm12 == 12'h000) || (inst.i.imm12 == 12'h001));

  always_comb begin
    // start from the register fields of the word and trim them per format
    meta            = '0;
    meta.valid      = 1'b1;
    meta.rs1        = inst.r.rs1;
    meta.rs2        = inst.r.rs2;
    meta.rd         = inst.r.rd;
    meta.result_src = hazard_pkg::result_src_alu;

    case (inst.r.opcode)
      hazard_pkg::opcode_load: begin
        // loads write from the data memory read port, no rs2
        meta.rs2        = 5'd0;
        meta.result_src = hazard_pkg::result_src_dmem_rd_data;
      end
      hazard_pkg::opcode_store,
      hazard_pkg::opcode_branch: begin
        // stores and branches read both sources and never write a register
        meta.rd = 5'd0;
      end
      hazard_pkg::opcode_jal: begin
        // jal has only a destination, the link value is pc plus four
        meta.rs1        = 5'd0;
        meta.rs2        = 5'd0;
        meta.result_src = hazard_pkg::result_src_pc_plus4;
      end
      hazard_pkg::opcode_jalr: begin
        meta.rs2        = 5'd0;
        meta.result_src = hazard_pkg::result_src_pc_plus4;
      end
      hazard_pkg::opcode_op: begin
        // full r-type, all three register fields are live
        meta.result_src = hazard_pkg::result_src_alu;
      end
      hazard_pkg::opcode_op_imm: begin
        meta.rs2 = 5'd0;
      end
      hazard_pkg::opcode_lui,
      hazard_pkg::opcode_auipc: begin
        // upper immediate forms carry no source register at all
        meta.rs1 = 5'd0;
        meta.rs2 = 5'd0;
      end
      hazard_pkg::opcode_system: begin
        // every system word traps, env calls have no register operands
        meta.trap = 1'b1;
        meta.rs2  = 5'd0;
        if (is_env_call) begin
          meta.rs1 = 5'd0;
          meta.rd  = 5'd0;
        end
      end
      default: begin
        // an unknown opcode is an illegal instruction trap without operands
        meta.rs1  = 5'd0;
        meta.rs2  = 5'd0;
        meta.rd   = 5'd0;
        meta.trap = 1'b1;
      end
    endcase

    // no strobe means a bubble enters ID
    if (!inst_valid) begin
      meta = '0;
    end
  end

endmodule

// ==== rtl/hazard_pkg.sv ====
package hazard_pkg;

  // number of stage registers between fetch and retirement
  // index 0 holds the instruction in ID and index 4 the one in WB
  localparam int num_stages = 5;

  // result source of an instruction, selected in the write back stage
  localparam logic [1:0] result_src_alu          = 2'd0;
  localparam logic [1:0] result_src_dmem_rd_data = 2'd1;
  localparam logic [1:0] result_src_pc_plus4     = 2'd2;

  // operand select codes for the two EX stage operand muxes
  localparam logic [2:0] fwd_no_forward      = 3'd0;
  localparam logic [2:0] fwd_mem1_alu_result = 3'd1;
  localparam logic [2:0] fwd_mem2_mem_rdata  = 3'd2;
  localparam logic [2:0] fwd_mem2_alu_result = 3'd3;
  localparam logic [2:0] fwd_wb_result       = 3'd4;

  // base opcodes of the RV32I instruction set
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // register to register layout, also the source of rs2 for stores and branches
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // immediate layout, the upper twelve bits tell ecall from ebreak
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // one fetched word seen through either field layout
  typedef union packed {
    logic [31:0] raw;
    inst_r_t     r;
    inst_i_t     i;
  } inst_word_u;

  // what the hazard logic needs to know about the instruction in a stage
  // an all zero record is a bubble and can never match a live register
  typedef struct packed {
    logic       valid;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [1:0] result_src;
    logic       trap;
  } stage_meta_t;

  // operand selects for EX and the register file bypass bits for ID
  typedef struct packed {
    logic [2:0] ex_a;
    logic [2:0] ex_b;
    logic       id_a;
    logic       id_b;
  } fwd_sel_t;

endpackage
